//--- filelist.f
verilog/backup_pkg.sv
verilog/backup_request_ctrl.sv
verilog/nvram_buffer.sv
verilog/sector_transfer_seq.sv
verilog/backup_ram_top.sv
test/tb_clock_gen.sv
test/sd_host_model.sv
test/tb_backup_ram.sv

//--- test/backup_stimulus.txt
// One word per line: tag (2 hex), address (4 hex), data (2 hex)
// Tags: 01 sector seed, 02 console write, 03 readback after load, 04 write before autosave, ff end
01000011
010001a0
0100023c
010003f7
03000011
0300ff10
0301ff10
030200a0
030305a5
03047fbb
030600f7
0307fff6
0200035a
020201c3
02055500
0207fe99
040100e1
ff000000

//--- test/sd_host_model.sv
// Block-device host stand-in; serves one request at a time and logs at most LOG_DEPTH requests
`timescale 1ns/100ps

module sd_host_model #(
	parameter int          NUM_SECT      = 4,
	parameter int          SECTOR_ADDR_W = 9,
	parameter int          LOG_DEPTH     = 64,
	parameter int unsigned SEED          = 32'h812b_3ea1
) (
	input  logic                     clk_sys,
	input  logic [8*NUM_SECT-1:0]    seeds,
	input  logic                     sd_rd,
	input  logic                     sd_wr,
	input  logic [31:0]              sd_lba,
	input  logic [7:0]               sd_buff_din,
	output logic                     sd_ack,
	output logic [SECTOR_ADDR_W-1:0] sd_buff_addr,
	output logic [7:0]               sd_buff_dout,
	output logic                     sd_buff_wr
);

	localparam int SECT_BYTES = 2 ** SECTOR_ADDR_W;

	// Bytes captured during saves, and the request history
	logic [7:0]  cap [NUM_SECT * SECT_BYTES];
	logic [31:0] log_lba [LOG_DEPTH];
	logic [1:0]  log_kind [LOG_DEPTH];
	int          log_count;

	initial begin : serve
		int unsigned rng_seed;
		int unsigned delay;
		int          sect;
		logic        is_rd;
		rng_seed     = SEED;
		delay        = $urandom(rng_seed);
		sd_ack       = 1'b0;
		sd_buff_addr = '0;
		sd_buff_dout = '0;
		sd_buff_wr   = 1'b0;
		log_count    = 0;
		forever begin
			@(posedge clk_sys);
			#10;
			if (sd_rd === 1'b1 || sd_wr === 1'b1) begin
				is_rd = sd_rd;
				sect  = int'(sd_lba % NUM_SECT);
				if (log_count < LOG_DEPTH) begin
					log_lba[log_count]  = sd_lba;
					log_kind[log_count] = {sd_wr, sd_rd};
				end
				log_count++;
				// Random hold-off before taking the request
				delay = ($urandom % 8) + 1;
				repeat (delay) @(posedge clk_sys);
				#10;
				sd_ack = 1'b1;
				for (int i = 0; i < SECT_BYTES; i++) begin
					sd_buff_addr = SECTOR_ADDR_W'(i);
					if (is_rd) begin
						sd_buff_dout = seeds[8*sect +: 8] + 8'(i);
						sd_buff_wr   = 1'b1;
					end
					@(posedge clk_sys);
					#10;
					// Registered RAM read shows up one cycle after the address
					if (!is_rd)
						cap[sect * SECT_BYTES + i] = sd_buff_din;
				end
				sd_buff_wr = 1'b0;
				sd_ack     = 1'b0;
			end
		end
	end

endmodule

//--- test/tb_backup_ram.sv
// Runs with a 2 KiB save RAM in four sectors; reads test/backup_stimulus.txt from the project root
`timescale 1ns/100ps

module tb_backup_ram;

	localparam int NVRAM_ADDR_W  = 11;
	localparam int SECTOR_ADDR_W = 9;
	localparam int NUM_SECT      = 2 ** (NVRAM_ADDR_W - SECTOR_ADDR_W);
	localparam int NV_DEPTH      = 2 ** NVRAM_ADDR_W;
	localparam int CLK_PERIOD    = 100;
	localparam int NUM_TESTS     = 6;
	localparam int XFER_LIMIT    = NUM_SECT * 600;
	localparam int WATCHDOG_CYC  = XFER_LIMIT * NUM_TESTS + 8000;

	logic                     clk_sys, reset;
	logic [NVRAM_ADDR_W-1:0]  nv_addr;
	logic                     nv_we;
	logic [7:0]               nv_wdata, nv_rdata;
	logic                     download, img_mounted, img_readonly;
	logic [63:0]              img_size;
	logic                     osd_open, load_req, save_req, autosave_en;
	logic                     sd_ack, sd_buff_wr;
	logic [SECTOR_ADDR_W-1:0] sd_buff_addr;
	logic [7:0]               sd_buff_dout, sd_buff_din;
	logic [31:0]              sd_lba;
	logic                     sd_rd, sd_wr, loading, busy, pending;

	logic [31:0]              stim [64];
	logic [8*NUM_SECT-1:0]    seeds;
	logic [7:0]               exp_ram [NV_DEPTH];
	int                       checks, errors;

	tb_clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(3)) clk0 (.clk_sys(clk_sys), .reset(reset));

	backup_ram_top #(.NVRAM_ADDR_W(NVRAM_ADDR_W), .SECTOR_ADDR_W(SECTOR_ADDR_W)) dut0 (.*);

	sd_host_model #(
		.NUM_SECT(NUM_SECT), .SECTOR_ADDR_W(SECTOR_ADDR_W), .SEED(32'h812b_3ea1)
	) host0 (
		.clk_sys(clk_sys), .seeds(seeds), .sd_rd(sd_rd), .sd_wr(sd_wr), .sd_lba(sd_lba),
		.sd_buff_din(sd_buff_din), .sd_ack(sd_ack), .sd_buff_addr(sd_buff_addr),
		.sd_buff_dout(sd_buff_dout), .sd_buff_wr(sd_buff_wr)
	);

	// ========================================
	// Helpers
	// ========================================

	task automatic step(input int n);
		repeat (n) @(posedge clk_sys);
		#10;
	endtask

	task automatic compare_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		assert (actual === expected)
		else begin
			errors++;
			$display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	task automatic require(input logic cond, input string what);
		checks++;
		assert (cond === 1'b1)
		else begin
			errors++;
			$display("ERROR: %s", what);
		end
	endtask

	task automatic console_write(input logic [15:0] addr, input logic [7:0] data);
		nv_addr  = addr[NVRAM_ADDR_W-1:0];
		nv_wdata = data;
		nv_we    = 1'b1;
		step(1);
		nv_we    = 1'b0;
		exp_ram[addr[NVRAM_ADDR_W-1:0]] = data;
	endtask

	// Walks the stimulus words up to the end marker
	task automatic apply_writes(input logic [7:0] tag);
		for (int i = 0; i < 64; i++) begin
			if (stim[i][31:24] === 8'hff || ^stim[i] === 1'bx)
				break;
			if (stim[i][31:24] == tag)
				console_write(stim[i][23:8], stim[i][7:0]);
		end
	endtask

	task automatic verify_readback(input string name);
		for (int a = 0; a < NV_DEPTH; a++) begin
			nv_addr = NVRAM_ADDR_W'(a);
			step(1);
			compare_value($sformatf("%s byte %0h", name, a), exp_ram[a], nv_rdata);
		end
		for (int i = 0; i < 64; i++) begin
			if (stim[i][31:24] === 8'hff || ^stim[i] === 1'bx)
				break;
			if (stim[i][31:24] == 8'h03) begin
				nv_addr = stim[i][8 +: NVRAM_ADDR_W];
				step(1);
				compare_value($sformatf("%s listed %0h", name, nv_addr), stim[i][7:0],
					nv_rdata);
			end
		end
	endtask

	task automatic wait_start(input string name, input logic exp_loading);
		int n;
		n = 0;
		while (busy !== 1'b1 && n < 20) begin
			step(1);
			n++;
		end
		require(busy === 1'b1, $sformatf("%s: transfer never started", name));
		compare_value($sformatf("%s loading", name), exp_loading, loading);
	endtask

	task automatic wait_end(input string name);
		int n;
		n = 0;
		while (busy === 1'b1 && n < XFER_LIMIT) begin
			step(1);
			n++;
		end
		require(busy === 1'b0, $sformatf("%s: transfer never finished", name));
	endtask

	task automatic verify_sectors(input string name, input int first, input logic [1:0] kind);
		compare_value($sformatf("%s request count", name), first + NUM_SECT, host0.log_count);
		for (int k = 0; k < NUM_SECT; k++) begin
			compare_value($sformatf("%s lba %0d", name, k), k, host0.log_lba[first + k]);
			compare_value($sformatf("%s strobe %0d", name, k), kind, host0.log_kind[first + k]);
		end
	endtask

	task automatic compare_capture(input string name);
		for (int a = 0; a < NV_DEPTH; a++)
			compare_value($sformatf("%s byte %0h", name, a), exp_ram[a], host0.cap[a]);
	endtask

	task automatic expect_idle(input string name, input int cycles);
		logic seen;
		seen = 1'b0;
		for (int n = 0; n < cycles; n++) begin
			step(1);
			if (sd_rd === 1'b1 || sd_wr === 1'b1 || busy === 1'b1)
				seen = 1'b1;
		end
		require(!seen, $sformatf("%s: a transfer started when none was expected", name));
	endtask

	task automatic mount_image(input logic readonly, input logic [63:0] size);
		download = 1'b1;
		step(2);
		img_readonly = readonly;
		img_mounted  = 1'b1;
		step(1);
		img_mounted  = 1'b0;
		img_size     = size;
		step(2);
		download     = 1'b0;
	endtask

	// ========================================
	// Test sequence
	// ========================================

	initial begin : main
		int first;
		{nv_addr, nv_we, nv_wdata, download, img_mounted, img_readonly} = '0;
		{img_size, osd_open, load_req, save_req, autosave_en} = '0;
		checks = 0;
		errors = 0;
		seeds  = '0;
		$readmemh("test/backup_stimulus.txt", stim);
		for (int i = 0; i < 64; i++) begin
			if (stim[i][31:24] === 8'hff || ^stim[i] === 1'bx)
				break;
			if (stim[i][31:24] == 8'h01)
				seeds[8*stim[i][15:8] +: 8] = stim[i][7:0];
		end
		// Image byte i of sector s is seed s plus i
		for (int a = 0; a < NV_DEPTH; a++)
			exp_ram[a] = seeds[8*(a >> SECTOR_ADDR_W) +: 8] + 8'(a);
		wait (reset === 1'b0);
		step(1);

		compare_value("reset outputs", 5'b0, {sd_rd, sd_wr, busy, loading, pending});
		save_req = 1'b1;
		step(1);
		save_req = 1'b0;
		expect_idle("save before mount", 50);

		mount_image(1'b0, 64'd2048);
		wait_start("auto load", 1'b1);
		wait_end("auto load");
		verify_sectors("auto load", 0, 2'b01);
		verify_readback("auto load readback");

		apply_writes(8'h02);
		compare_value("write sets pending", 1, pending);
		first    = host0.log_count;
		save_req = 1'b1;
		step(1);
		save_req = 1'b0;
		wait_start("user save", 1'b0);
		wait_end("user save");
		verify_sectors("user save", first, 2'b10);
		compare_capture("user save");
		compare_value("user save pending", 0, pending);

		// Autosave only with menu open and autosave on
		apply_writes(8'h04);
		osd_open = 1'b1;
		expect_idle("menu without autosave", 20);
		osd_open    = 1'b0;
		autosave_en = 1'b1;
		expect_idle("autosave with menu closed", 20);
		first    = host0.log_count;
		osd_open = 1'b1;
		wait_start("autosave", 1'b0);
		wait_end("autosave");
		verify_sectors("autosave", first, 2'b10);
		compare_capture("autosave");
		compare_value("autosave pending", 0, pending);
		osd_open    = 1'b0;
		autosave_en = 1'b0;

		first    = host0.log_count;
		load_req = 1'b1;
		wait_start("user load", 1'b1);
		load_req = 1'b0;
		while (sd_lba == '0 && busy === 1'b1)
			step(1);
		save_req = 1'b1;
		load_req = 1'b1;
		step(2);
		save_req = 1'b0;
		load_req = 1'b0;
		wait_end("user load");
		expect_idle("after user load", 50);
		verify_sectors("user load", first, 2'b01);

		mount_image(1'b1, 64'd2048);
		expect_idle("readonly download end", 20);
		save_req = 1'b1;
		step(1);
		save_req = 1'b0;
		expect_idle("readonly save", 50);
		console_write(16'h0010, 8'h77);
		compare_value("readonly pending", 0, pending);

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin : watchdog
		#(WATCHDOG_CYC * CLK_PERIOD);
		$display("ERROR: watchdog expired after %0d cycles, the run hung", WATCHDOG_CYC);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

//--- test/tb_clock_gen.sv
// Free-running clock from time zero; reset releases a fixed 10 ns after a rising edge
`timescale 1ns/100ps

module tb_clock_gen #(
	parameter int PERIOD       = 100,
	parameter int RESET_CYCLES = 3
) (
	output logic clk_sys,
	output logic reset
);

	initial begin
		clk_sys = 1'b0;
		forever #(PERIOD / 2) clk_sys = ~clk_sys;
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		#10;
		reset = 1'b0;
	end

endmodule

//--- verilog/backup_pkg.sv
// Shared save-RAM types and default sizes; NVRAM_ADDR_W_DEF must stay above SECTOR_ADDR_W_DEF

package backup_pkg;

	// ========================================
	// Data types
	// ========================================

	// One byte of save RAM or of the block-device sector buffer
	typedef logic [7:0] byte_t;

	// Sequencer state, idle or moving sectors in one direction
	typedef enum logic [1:0] {
		XFER_IDLE = 2'd0,
		XFER_LOAD = 2'd1,
		XFER_SAVE = 2'd2
	} xfer_state_t;

	// ========================================
	// Default sizes
	// ========================================

	// 32 KiB save RAM
	localparam int NVRAM_ADDR_W_DEF  = 15;

	// 512-byte sectors
	localparam int SECTOR_ADDR_W_DEF = 9;

	// Sector address as seen by the block-device host
	localparam int LBA_W             = 32;

endpackage

//--- verilog/backup_ram_top.sv
// Backup RAM with block-device transfer; the console should be held off while loading is high
`timescale 1ns/100ps

module backup_ram_top
	import backup_pkg::*;
#(
	parameter int NVRAM_ADDR_W  = NVRAM_ADDR_W_DEF,
	parameter int SECTOR_ADDR_W = SECTOR_ADDR_W_DEF
) (
	input  logic                     clk_sys,
	input  logic                     reset,

	// Console save RAM
	input  logic [NVRAM_ADDR_W-1:0]  nv_addr,
	input  logic                     nv_we,
	input  byte_t                    nv_wdata,
	output byte_t                    nv_rdata,

	// Host control
	input  logic                     download,
	input  logic                     img_mounted,
	input  logic                     img_readonly,
	input  logic [63:0]              img_size,
	input  logic                     osd_open,
	input  logic                     load_req,
	input  logic                     save_req,
	input  logic                     autosave_en,

	// Block device
	input  logic                     sd_ack,
	input  logic [SECTOR_ADDR_W-1:0] sd_buff_addr,
	input  byte_t                    sd_buff_dout,
	input  logic                     sd_buff_wr,
	output logic [LBA_W-1:0]         sd_lba,
	output logic                     sd_rd,
	output logic                     sd_wr,
	output byte_t                    sd_buff_din,

	// Status
	output logic                     loading,
	output logic                     busy,
	output logic                     pending
);

	logic                    start_load;
	logic                    start_save;
	logic [NVRAM_ADDR_W-1:0] buf_addr;
	logic                    buf_we;

	backup_request_ctrl #(
		.NVRAM_ADDR_W  (NVRAM_ADDR_W),
		.SECTOR_ADDR_W (SECTOR_ADDR_W)
	) u_request_ctrl (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.download     (download),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_size     (img_size),
		.osd_open     (osd_open),
		.load_req     (load_req),
		.save_req     (save_req),
		.autosave_en  (autosave_en),
		.nv_we        (nv_we),
		.busy         (busy),
		.start_load   (start_load),
		.start_save   (start_save),
		.pending      (pending)
	);

	// Port a is the console, port b the sector buffer
	nvram_buffer #(
		.NVRAM_ADDR_W (NVRAM_ADDR_W)
	) u_nvram_buffer (
		.clk_sys (clk_sys),
		.a_addr  (nv_addr),
		.a_we    (nv_we),
		.a_wdata (nv_wdata),
		.a_rdata (nv_rdata),
		.b_addr  (buf_addr),
		.b_we    (buf_we),
		.b_wdata (sd_buff_dout),
		.b_rdata (sd_buff_din)
	);

	sector_transfer_seq #(
		.NVRAM_ADDR_W  (NVRAM_ADDR_W),
		.SECTOR_ADDR_W (SECTOR_ADDR_W)
	) u_sector_seq (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.start_load   (start_load),
		.start_save   (start_save),
		.sd_ack       (sd_ack),
		.sd_buff_addr (sd_buff_addr),
		.sd_buff_wr   (sd_buff_wr),
		.sd_lba       (sd_lba),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.loading      (loading),
		.busy         (busy),
		.buf_addr     (buf_addr),
		.buf_we       (buf_we)
	);

endmodule

//--- verilog/backup_request_ctrl.sv
// Single clock domain; requests stay ignored until a writable image is mounted during a download
`timescale 1ns/100ps

module backup_request_ctrl
	import backup_pkg::*;
#(
	parameter int NVRAM_ADDR_W  = NVRAM_ADDR_W_DEF,
	parameter int SECTOR_ADDR_W = SECTOR_ADDR_W_DEF
) (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        download,
	input  logic        img_mounted,
	input  logic        img_readonly,
	input  logic [63:0] img_size,
	input  logic        osd_open,
	input  logic        load_req,
	input  logic        save_req,
	input  logic        autosave_en,
	input  logic        nv_we,
	input  logic        busy,
	output logic        start_load,
	output logic        start_save,
	output logic        pending
);

	logic download_q;
	logic dl_rise;
	logic dl_fall;
	logic bk_ena;
	logic img_big;
	logic img_secs;
	logic img_tail;
	logic img_nonempty;
	logic auto_save;
	logic auto_load;
	logic load_lvl;
	logic save_lvl;
	logic load_q;
	logic save_q;
	logic load_edge;
	logic save_edge;

	// ========================================
	// Download and image events
	// ========================================

	assign dl_rise = download & ~download_q;
	assign dl_fall = ~download & download_q;

	// Image size split into beyond-RAM, whole sectors and partial sector
	assign img_big      = |img_size[63:NVRAM_ADDR_W];
	assign img_secs     = |img_size[NVRAM_ADDR_W-1:SECTOR_ADDR_W];
	assign img_tail     = |img_size[SECTOR_ADDR_W-1:0];
	assign img_nonempty = img_big | img_secs | img_tail;

	// Save file is mounted just before the download finishes
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			download_q <= 1'b0;
			bk_ena     <= 1'b0;
		end else begin
			download_q <= download;
			if (dl_rise)
				bk_ena <= 1'b0;
			if (download && img_mounted && !img_readonly)
				bk_ena <= 1'b1;
		end
	end

	// ========================================
	// Request edges
	// ========================================

	// Autosave folds into the save level so it fires once per menu opening
	assign auto_save = pending & osd_open & autosave_en;
	assign auto_load = dl_fall & img_nonempty & bk_ena;

	assign load_lvl  = load_req & bk_ena;
	assign save_lvl  = (save_req | auto_save) & bk_ena;
	assign load_edge = load_lvl & ~load_q;
	assign save_edge = save_lvl & ~save_q;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			load_q     <= 1'b0;
			save_q     <= 1'b0;
			start_load <= 1'b0;
			start_save <= 1'b0;
		end else begin
			load_q     <= load_lvl;
			save_q     <= save_lvl;
			start_load <= load_edge | auto_load;
			start_save <= save_edge;
		end
	end

	// Console writes outside the menu mark the RAM dirty
	always_ff @(posedge clk_sys) begin
		if (reset)
			pending <= 1'b0;
		else if (bk_ena && !osd_open && nv_we)
			pending <= 1'b1;
		else if (busy)
			pending <= 1'b0;
	end

endmodule

//--- verilog/nvram_buffer.sv
// Read-first true dual-port byte RAM on one clock; contents are undefined after power-up
`timescale 1ns/100ps

module nvram_buffer
	import backup_pkg::*;
#(
	parameter int NVRAM_ADDR_W = NVRAM_ADDR_W_DEF
) (
	input  logic                    clk_sys,

	// Console side
	input  logic [NVRAM_ADDR_W-1:0] a_addr,
	input  logic                    a_we,
	input  byte_t                   a_wdata,
	output byte_t                   a_rdata,

	// Sector buffer side
	input  logic [NVRAM_ADDR_W-1:0] b_addr,
	input  logic                    b_we,
	input  byte_t                   b_wdata,
	output byte_t                   b_rdata
);

	localparam int DEPTH = 2 ** NVRAM_ADDR_W;

	byte_t mem [DEPTH];

	// ========================================
	// Port a
	// ========================================

	always @(posedge clk_sys) begin
		a_rdata <= mem[a_addr];
		if (a_we)
			mem[a_addr] <= a_wdata;
	end

	// ========================================
	// Port b
	// ========================================

	// Old data is returned on a same-cycle write
	always @(posedge clk_sys) begin
		b_rdata <= mem[b_addr];
		if (b_we)
			mem[b_addr] <= b_wdata;
	end

endmodule

//--- verilog/sector_transfer_seq.sv
// Walks every sector of the save RAM from LBA 0; waits on sd_ack forever, no timeout
`timescale 1ns/100ps

module sector_transfer_seq
	import backup_pkg::*;
#(
	parameter int NVRAM_ADDR_W  = NVRAM_ADDR_W_DEF,
	parameter int SECTOR_ADDR_W = SECTOR_ADDR_W_DEF
) (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     start_load,
	input  logic                     start_save,
	input  logic                     sd_ack,
	input  logic [SECTOR_ADDR_W-1:0] sd_buff_addr,
	input  logic                     sd_buff_wr,
	output logic [LBA_W-1:0]         sd_lba,
	output logic                     sd_rd,
	output logic                     sd_wr,
	output logic                     loading,
	output logic                     busy,
	output logic [NVRAM_ADDR_W-1:0]  buf_addr,
	output logic                     buf_we
);

	// Sector index bits inside sd_lba
	localparam int SECT_W = NVRAM_ADDR_W - SECTOR_ADDR_W;

	xfer_state_t state;
	logic        ack_q;
	logic        ack_rise;
	logic        ack_fall;
	logic        last_sector;

	// ========================================
	// Acknowledge edges
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (reset)
			ack_q <= 1'b0;
		else
			ack_q <= sd_ack;
	end

	assign ack_rise    = sd_ack & ~ack_q;
	assign ack_fall    = ~sd_ack & ack_q;
	assign last_sector = &sd_lba[SECT_W-1:0];

	// ========================================
	// Status and buffer port
	// ========================================

	assign busy     = (state != XFER_IDLE);
	assign loading  = (state == XFER_LOAD);
	assign buf_addr = {sd_lba[SECT_W-1:0], sd_buff_addr};
	assign buf_we   = sd_buff_wr & sd_ack;

	// ========================================
	// Transfer FSM
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state  <= XFER_IDLE;
			sd_lba <= '0;
			sd_rd  <= 1'b0;
			sd_wr  <= 1'b0;
		end else begin
			// Host has taken the request
			if (ack_rise) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			case (state)
				XFER_IDLE: begin
					// Load wins when both arrive together
					if (start_load) begin
						state  <= XFER_LOAD;
						sd_lba <= '0;
						sd_rd  <= 1'b1;
						sd_wr  <= 1'b0;
					end else if (start_save) begin
						state  <= XFER_SAVE;
						sd_lba <= '0;
						sd_rd  <= 1'b0;
						sd_wr  <= 1'b1;
					end
				end

				XFER_LOAD, XFER_SAVE: begin
					// Sector done once the host releases sd_ack
					if (ack_fall) begin
						if (last_sector) begin
							state <= XFER_IDLE;
						end else begin
							sd_lba <= sd_lba + LBA_W'(1);
							sd_rd  <= (state == XFER_LOAD);
							sd_wr  <= (state == XFER_SAVE);
						end
					end
				end

				default: begin
					state <= XFER_IDLE;
				end
			endcase
		end
	end

endmodule
